// File: loader_pkg.sv
// Loader bus widths, header offsets and shared types, referenced by scoped name from each module
package loader_pkg;

	typedef logic [24:0] addr_t;   // Byte address of the download
	typedef logic [15:0] word_t;   // Download data word
	typedef logic [7:0]  index_t;  // File type index, all ones is a cheat file

	typedef enum logic [1:0] {JP = 2'd0, US = 2'd1, EU = 2'd2} region_t;

	// Auto-region priority orders
	typedef enum logic [1:0] {US_EU_JP, EU_US_JP, US_JP_EU, JP_US_EU} prio_t;

	typedef struct packed {
		logic  auto_en;
		logic  use_header;  // Header letters, else file index
		prio_t prio;
	} region_cfg_t;

	// Download event as seen by the datapath blocks
	typedef struct packed {
		logic  dl_start;  // Cartridge download rising edge
		logic  dl_end;    // Cartridge download falling edge
		logic  cart_wr;
		addr_t addr;
		word_t data;
	} load_ev_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	////////////////////////////////////////////////////////////////////////////
	// Cartridge header layout
	localparam addr_t HDR_REGION0 = 25'h1F0;  // Region letters or code
	localparam addr_t HDR_REGION1 = 25'h1F2;
	localparam addr_t HDR_DONE    = 25'h200;  // First word past the header
	localparam addr_t ID_FIRST    = 25'h182;  // Serial number start
	localparam addr_t ID_DECIDE   = 25'h18C;  // Serial complete here

endpackage

// File: title_db_pkg.sv
// Title database of known cartridge serials with their quirk and light-gun settings
package title_db_pkg;

	typedef logic [63:0] cart_id_t;  // Eight ASCII characters

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;   // Fake RAM check
		logic fifo;    // Fast VDP FIFO
		logic pier;
		logic svp;
		logic fmbusy;
		logic schan;
	} quirks_t;

	typedef struct packed {
		logic       gun_type;
		logic [7:0] sensor_delay;  // Sensor offset in pixels
	} gun_cfg_t;

	////////////////////////////////////////////////////////////////////////////
	// Serials with a mapper or timing quirk
	localparam cart_id_t SRAM_ID0   = "T-081276";
	localparam cart_id_t SRAM_ID1   = "T-81406 ";
	localparam cart_id_t EEPROM_ID0 = "MK-1215 ";
	localparam cart_id_t EEPROM_ID1 = "G-4060  ";
	localparam cart_id_t NORAM_ID   = "T-113016";
	localparam cart_id_t FIFO_ID    = "T-89016 ";
	localparam cart_id_t PIER_ID    = "T-574023";
	localparam cart_id_t SVP_ID     = "MK-1229 ";
	localparam cart_id_t FMBUSY_ID  = "T-35036 ";

	// Light-gun titles
	localparam cart_id_t GUN0_ID = "MK-1533 ";
	localparam cart_id_t GUN1_ID = "T-95096-";
	localparam cart_id_t GUN2_ID = "T-95136-";

	localparam gun_cfg_t GUN0_CFG    = '{gun_type: 1'b0, sensor_delay: 8'd100};
	localparam gun_cfg_t GUN1_CFG    = '{gun_type: 1'b1, sensor_delay: 8'd52};
	localparam gun_cfg_t GUN2_CFG    = '{gun_type: 1'b1, sensor_delay: 8'd30};
	localparam gun_cfg_t GUN_DEFAULT = '{gun_type: 1'b0, sensor_delay: 8'd44};

endpackage

// File: load_ctrl.sv
// Download control: edge pulses, ROM write toggle with host wait, size latch and cheat words
`timescale 1ns/1ps

module load_ctrl (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    download,
	input  loader_pkg::index_t      index,
	input  logic                    wr,
	input  loader_pkg::addr_t       addr,
	input  loader_pkg::word_t       data,
	input  logic                    rom_ack,
	output logic                    rom_wr,
	output logic                    ioctl_wait,
	output loader_pkg::addr_t       rom_sz,
	output loader_pkg::load_ev_t    ev,
	output loader_pkg::cheat_code_t code,
	output logic                    code_valid,
	output logic                    code_reset
);

	logic              code_index;
	logic              cart_dl;
	logic              code_dl;
	logic              cheat_wr;
	logic              old_cart_dl;
	loader_pkg::word_t data_sw;

	assign code_index = &index;  // All ones selects the cheat file
	assign cart_dl    = download & ~code_index;
	assign code_dl    = download & code_index;
	assign cheat_wr   = code_dl & wr;
	assign data_sw    = {data[7:0], data[15:8]};

	// Event bus to the header, title and region blocks
	assign ev.dl_start = cart_dl & ~old_cart_dl;
	assign ev.dl_end   = old_cart_dl & ~cart_dl;
	assign ev.cart_wr  = cart_dl & wr;
	assign ev.addr     = addr;
	assign ev.data     = data;

	////////////////////////////////////////////////////////////////////////////
	// ROM write handshake
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_cart_dl <= 1'b0;
			rom_wr      <= 1'b0;
			ioctl_wait  <= 1'b0;
		end else begin
			old_cart_dl <= cart_dl;
			if (ev.cart_wr) begin
				rom_wr     <= ~rom_wr;  // New request
				ioctl_wait <= 1'b1;
			end else if (ioctl_wait && (rom_wr == rom_ack)) begin
				ioctl_wait <= 1'b0;     // Memory has caught up
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ev.dl_end)
			rom_sz <= addr;  // Last address of the file
	end

	////////////////////////////////////////////////////////////////////////////
	// Cheat code assembly, one code per 16 bytes
	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (addr[3:0])
				4'd0:  code.flags[15:0]    <= data_sw;
				4'd2:  code.flags[31:16]   <= data_sw;
				4'd4:  code.address[15:0]  <= data_sw;
				4'd6:  code.address[31:16] <= data_sw;
				4'd8:  code.compare[15:0]  <= data_sw;
				4'd10: code.compare[31:16] <= data_sw;
				4'd12: code.replace[15:0]  <= data_sw;
				4'd14: code.replace[31:16] <= data_sw;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_valid <= 1'b0;
			code_reset <= 1'b0;
		end else begin
			code_valid <= cheat_wr && (addr[3:0] == 4'd14);  // Last word of a code
			code_reset <= cheat_wr && (addr == '0);          // New cheat list
		end
	end

	// Host holds off while the memory is still busy with the last word
	no_wr_while_wait: assert property (@(posedge clk_sys) disable iff (RESET)
		ioctl_wait |-> !wr);

endmodule

// File: hdr_region.sv
// Header region parser: decodes region letters or codes and flags when the header has passed
`timescale 1ns/1ps

module hdr_region (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  loader_pkg::load_ev_t ev,
	output logic                 hdr_ready,
	output logic                 hdr_j,
	output logic                 hdr_u,
	output logic                 hdr_e
);

	logic [7:0] lo;
	logic [7:0] hi;
	logic [3:0] hrgn;
	logic [2:0] flags;      // {e, u, j}
	logic [2:0] flags_nxt;

	// Region letter to flag mask, {e, u, j}
	function automatic logic [2:0] letter_mask(input logic [7:0] c);
		case (c)
			"J":     return 3'b001;
			"U":     return 3'b010;
			"E":     return 3'b100;
			default: return 3'b000;
		endcase
	endfunction

	assign lo   = ev.data[7:0];
	assign hi   = ev.data[15:8];
	assign hrgn = ev.data[3:0] - 4'd7;  // Hex letter A-F to 10-15

	always_comb begin
		flags_nxt = flags;
		if (ev.dl_start)
			flags_nxt = '0;
		if (ev.cart_wr && (ev.addr == loader_pkg::HDR_REGION0)) begin
			if (letter_mask(lo) != 3'b000)
				flags_nxt = flags_nxt | letter_mask(lo);
			else if (lo >= "0" && lo <= "9")
				flags_nxt = {ev.data[3], ev.data[2], ev.data[0]};  // Numeric code
			else if (lo >= "A" && lo <= "F")
				flags_nxt = {hrgn[3], hrgn[2], hrgn[0]};
			flags_nxt = flags_nxt | letter_mask(hi);  // High byte letters only
		end
		if (ev.cart_wr && (ev.addr == loader_pkg::HDR_REGION1))
			flags_nxt = flags_nxt | letter_mask(lo);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			flags     <= '0;
			hdr_ready <= 1'b0;
		end else begin
			flags <= flags_nxt;
			if (ev.dl_end)
				hdr_ready <= 1'b0;
			else if (ev.cart_wr && (ev.addr == loader_pkg::HDR_DONE))
				hdr_ready <= 1'b1;
		end
	end

	assign {hdr_e, hdr_u, hdr_j} = flags;

endmodule

// File: title_quirks.sv
// Title lookup: gathers the cartridge serial and sets quirk flags and light-gun settings
`timescale 1ns/1ps

module title_quirks (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  loader_pkg::load_ev_t   ev,
	output title_db_pkg::quirks_t  quirks,
	output title_db_pkg::gun_cfg_t gun_cfg
);

	title_db_pkg::cart_id_t cart_id;
	title_db_pkg::quirks_t  hit;
	title_db_pkg::gun_cfg_t gun_nxt;
	loader_pkg::word_t      data_sw;

	assign data_sw = {ev.data[7:0], ev.data[15:8]};

	// Serial sits in header words, first and last ones half used
	always_ff @(posedge clk_sys) begin
		if (ev.cart_wr) begin
			case (ev.addr)
				loader_pkg::ID_FIRST:          cart_id[63:56] <= ev.data[15:8];
				loader_pkg::ID_FIRST + 25'd2:  cart_id[55:40] <= data_sw;
				loader_pkg::ID_FIRST + 25'd4:  cart_id[39:24] <= data_sw;
				loader_pkg::ID_FIRST + 25'd6:  cart_id[23:8]  <= data_sw;
				loader_pkg::ID_FIRST + 25'd8:  cart_id[7:0]   <= ev.data[7:0];
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Database match, first hit wins
	always_comb begin
		hit = '0;
		if (cart_id == title_db_pkg::SRAM_ID0 || cart_id == title_db_pkg::SRAM_ID1)
			hit.sram = 1'b1;
		else if (cart_id == title_db_pkg::EEPROM_ID0 || cart_id == title_db_pkg::EEPROM_ID1)
			hit.eeprom = 1'b1;
		else if (cart_id == title_db_pkg::NORAM_ID)
			hit.noram = 1'b1;
		else if (cart_id == title_db_pkg::FIFO_ID)
			hit.fifo = 1'b1;
		else if (cart_id == title_db_pkg::PIER_ID)
			hit.pier = 1'b1;
		else if (cart_id == title_db_pkg::SVP_ID)
			hit.svp = 1'b1;
		else if (cart_id == title_db_pkg::FMBUSY_ID)
			hit.fmbusy = 1'b1;
	end

	always_comb begin
		if (cart_id == title_db_pkg::GUN0_ID)
			gun_nxt = title_db_pkg::GUN0_CFG;
		else if (cart_id == title_db_pkg::GUN1_ID)
			gun_nxt = title_db_pkg::GUN1_CFG;
		else if (cart_id == title_db_pkg::GUN2_ID)
			gun_nxt = title_db_pkg::GUN2_CFG;
		else
			gun_nxt = title_db_pkg::GUN_DEFAULT;  // Any other title
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			quirks  <= '0;
			gun_cfg <= title_db_pkg::GUN_DEFAULT;
		end else if (ev.cart_wr && (ev.addr == loader_pkg::ID_DECIDE)) begin
			quirks  <= hit;
			gun_cfg <= gun_nxt;
		end else if (ev.dl_start) begin
			quirks <= '0;  // Gun settings kept until the next decision
		end
	end

endmodule

// File: region_select.sv
// Auto-region selection from header flags by priority order, or from the file type index
`timescale 1ns/1ps

module region_select (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  loader_pkg::region_cfg_t cfg,
	input  loader_pkg::index_t      index,
	input  logic                    hdr_ready,
	input  logic                    hdr_j,
	input  logic                    hdr_u,
	input  logic                    hdr_e,
	output loader_pkg::region_t     region_req,
	output logic                    region_set
);

	logic                old_ready;
	loader_pkg::region_t pick;

	// First present letter in priority order, else the order's first region
	always_comb begin
		case (cfg.prio)
			loader_pkg::US_EU_JP:
				pick = hdr_u ? loader_pkg::US : hdr_e ? loader_pkg::EU :
					hdr_j ? loader_pkg::JP : loader_pkg::US;
			loader_pkg::EU_US_JP:
				pick = hdr_e ? loader_pkg::EU : hdr_u ? loader_pkg::US :
					hdr_j ? loader_pkg::JP : loader_pkg::EU;
			loader_pkg::US_JP_EU:
				pick = hdr_u ? loader_pkg::US : hdr_j ? loader_pkg::JP :
					hdr_e ? loader_pkg::EU : loader_pkg::US;
			default:
				pick = hdr_j ? loader_pkg::JP : hdr_u ? loader_pkg::US :
					hdr_e ? loader_pkg::EU : loader_pkg::JP;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_ready  <= 1'b0;
			region_set <= 1'b0;
			region_req <= loader_pkg::JP;
		end else begin
			old_ready <= hdr_ready;
			if (cfg.auto_en && hdr_ready && !old_ready) begin
				if (cfg.use_header) begin
					region_set <= 1'b1;
					region_req <= pick;
				end else begin
					region_set <= |index;  // Index zero leaves the region alone
					region_req <= loader_pkg::region_t'(index[7:6]);
				end
			end else if (old_ready && !hdr_ready) begin
				region_set <= 1'b0;
			end
		end
	end

	// A requested region is always one of the three known codes
	region_in_range: assert property (@(posedge clk_sys) disable iff (RESET)
		region_set |-> region_req inside {loader_pkg::JP, loader_pkg::US, loader_pkg::EU});

endmodule

// File: cart_loader_top.sv
// Cartridge loader top level: control block feeding the header, title and region datapaths
`timescale 1ns/1ps

module cart_loader_top (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    download,
	input  loader_pkg::index_t      index,
	input  logic                    wr,
	input  loader_pkg::addr_t       addr,
	input  loader_pkg::word_t       data,
	input  logic                    rom_ack,
	output logic                    rom_wr,
	output logic                    ioctl_wait,
	input  loader_pkg::region_cfg_t cfg,
	output loader_pkg::addr_t       rom_sz,
	output loader_pkg::cheat_code_t code,
	output logic                    code_valid,
	output logic                    code_reset,
	output title_db_pkg::quirks_t   quirks,
	output title_db_pkg::gun_cfg_t  gun_cfg,
	output loader_pkg::region_t     region_req,
	output logic                    region_set
);

	loader_pkg::load_ev_t ev;
	logic                 hdr_ready;
	logic                 hdr_j;
	logic                 hdr_u;
	logic                 hdr_e;

	load_ctrl u_ctrl (.*);

	hdr_region u_hdr (.*);

	title_quirks u_title (.*);

	region_select u_region (.*);

endmodule

// File: tb_clock.sv
// Free-running system clock for the loader testbench, 10 ns period
`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys
);

	localparam time HALF = 5ns;

	initial clk_sys = 1'b0;
	always #(HALF) clk_sys = ~clk_sys;

endmodule

// File: cart_loader_tb.sv
// Loader testbench that drives host downloads, models the ROM acknowledge and checks the outputs
`timescale 1ns/1ps

module cart_loader_tb;

	localparam int CART_WORDS = 24;
	localparam int WORD_CYC   = 14;  // Worst cartridge write incl. ack delay
	localparam int DL_CYC     = 14;  // Download start, end and settle
	localparam int BUDGET     = 16 + CART_WORDS * WORD_CYC + DL_CYC
		+ 32 * (3 * WORD_CYC + DL_CYC) + 5 * (WORD_CYC + DL_CYC)
		+ 13 * (6 * WORD_CYC + DL_CYC) + 8 * 3 + DL_CYC + 400;

	logic                    clk_sys;
	logic                    RESET;
	logic                    download;
	loader_pkg::index_t      index;
	logic                    wr;
	loader_pkg::addr_t       addr;
	loader_pkg::word_t       data;
	logic                    rom_ack = 1'b0;
	loader_pkg::region_cfg_t cfg;
	logic                    rom_wr;
	logic                    ioctl_wait;
	loader_pkg::addr_t       rom_sz;
	loader_pkg::cheat_code_t code;
	logic                    code_valid;
	logic                    code_reset;
	title_db_pkg::quirks_t   quirks;
	title_db_pkg::gun_cfg_t  gun_cfg;
	loader_pkg::region_t     region_req;
	logic                    region_set;

	int                      checks = 0;
	int                      errors = 0;
	int unsigned             data_rnd = 32'd61529;
	int unsigned             ack_rnd = 32'd61529;
	int unsigned             ack_cnt = 0;
	int unsigned             last_delay = 0;
	int                      valid_pulses = 0;
	int                      reset_pulses = 0;
	loader_pkg::cheat_code_t exp_code = '0;

	// Header region words as {high byte, low byte}
	loader_pkg::word_t hdr_w0 [8] = '{" J", "UE", " 4", " 5", " C", " 8", "  ", "  "};
	loader_pkg::word_t hdr_w1 [8] = '{"  ", " J", "  ", "  ", "  ", "  ", " E", "  "};
	loader_pkg::prio_t prios [4] = '{loader_pkg::US_EU_JP, loader_pkg::EU_US_JP,
		loader_pkg::US_JP_EU, loader_pkg::JP_US_EU};
	loader_pkg::index_t idx_list [4] = '{8'h00, 8'h01, 8'h40, 8'h85};
	title_db_pkg::cart_id_t ids [13] = '{title_db_pkg::SRAM_ID0, title_db_pkg::SRAM_ID1,
		title_db_pkg::EEPROM_ID0, title_db_pkg::EEPROM_ID1, title_db_pkg::NORAM_ID,
		title_db_pkg::FIFO_ID, title_db_pkg::PIER_ID, title_db_pkg::SVP_ID,
		title_db_pkg::FMBUSY_ID, title_db_pkg::GUN0_ID, title_db_pkg::GUN1_ID,
		title_db_pkg::GUN2_ID, "T-12345 "};

	tb_clock clkgen (.clk_sys(clk_sys));

	cart_loader_top dut (.*);

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic loader_pkg::word_t rand_word();
		data_rnd = lcg_next(data_rnd);
		return loader_pkg::word_t'(data_rnd >> 16);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model of the loader rules
	function automatic logic [2:0] flag_of_letter(input logic [7:0] c);
		if (c == "J")
			return 3'b001;
		if (c == "U")
			return 3'b010;
		if (c == "E")
			return 3'b100;
		return 3'b000;
	endfunction

	// Header flags as {e, u, j}
	function automatic logic [2:0] header_flags(input loader_pkg::word_t w0,
		input loader_pkg::word_t w1);
		logic [7:0] lo;
		logic [7:0] v;
		logic [2:0] f;
		lo = w0[7:0];
		f = flag_of_letter(lo);
		if (f == 3'b000 && lo >= "0" && lo <= "9") begin
			v = lo - "0";
			f = {v[3], v[2], v[0]};
		end else if (f == 3'b000 && lo >= "A" && lo <= "F") begin
			v = lo - 8'h37;  // Hex digit value
			f = {v[3], v[2], v[0]};
		end
		return f | flag_of_letter(w0[15:8]) | flag_of_letter(w1[7:0]);
	endfunction

	function automatic loader_pkg::region_t pick_region(input logic [2:0] f,
		input loader_pkg::prio_t p);
		loader_pkg::region_t order [3];
		loader_pkg::region_t r;
		case (p)
			loader_pkg::US_EU_JP: order = '{loader_pkg::US, loader_pkg::EU, loader_pkg::JP};
			loader_pkg::EU_US_JP: order = '{loader_pkg::EU, loader_pkg::US, loader_pkg::JP};
			loader_pkg::US_JP_EU: order = '{loader_pkg::US, loader_pkg::JP, loader_pkg::EU};
			default:              order = '{loader_pkg::JP, loader_pkg::US, loader_pkg::EU};
		endcase
		r = order[0];  // Nothing present
		for (int i = 2; i >= 0; i--)
			if (f[order[i]])
				r = order[i];
		return r;
	endfunction

	function automatic title_db_pkg::quirks_t quirks_for_title(input title_db_pkg::cart_id_t id);
		title_db_pkg::quirks_t q;
		q = '0;
		case (id)
			title_db_pkg::SRAM_ID0, title_db_pkg::SRAM_ID1:     q.sram = 1'b1;
			title_db_pkg::EEPROM_ID0, title_db_pkg::EEPROM_ID1: q.eeprom = 1'b1;
			title_db_pkg::NORAM_ID:                             q.noram = 1'b1;
			title_db_pkg::FIFO_ID:                              q.fifo = 1'b1;
			title_db_pkg::PIER_ID:                              q.pier = 1'b1;
			title_db_pkg::SVP_ID:                               q.svp = 1'b1;
			title_db_pkg::FMBUSY_ID:                            q.fmbusy = 1'b1;
			default: ;
		endcase
		return q;
	endfunction

	function automatic title_db_pkg::gun_cfg_t gun_for_title(input title_db_pkg::cart_id_t id);
		case (id)
			title_db_pkg::GUN0_ID: return title_db_pkg::GUN0_CFG;
			title_db_pkg::GUN1_ID: return title_db_pkg::GUN1_CFG;
			title_db_pkg::GUN2_ID: return title_db_pkg::GUN2_CFG;
			default:               return title_db_pkg::GUN_DEFAULT;
		endcase
	endfunction

	// Word i sits at ws[16*i +: 16] and each field takes two swapped words
	function automatic loader_pkg::cheat_code_t assemble_cheat(input logic [127:0] ws);
		logic [15:0]             sw [8];
		loader_pkg::cheat_code_t c;
		for (int i = 0; i < 8; i++)
			sw[i] = {ws[16*i +: 8], ws[16*i+8 +: 8]};
		c.flags   = {sw[1], sw[0]};
		c.address = {sw[3], sw[2]};
		c.compare = {sw[5], sw[4]};
		c.replace = {sw[7], sw[6]};
		return c;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks and bus tasks entered on a falling edge
	task automatic expect_eq(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic test_done(input int num, input string name, input int mark);
		if (errors == mark)
			$display("Test %0d %s: ok", num, name);
		else
			$display("Test %0d %s: failed with %0d errors", num, name, errors - mark);
	endtask

	task automatic write_word(input loader_pkg::addr_t a, input loader_pkg::word_t d,
		input logic cart);
		logic prev_wr;
		logic exp_wr;
		int   high;
		prev_wr = rom_wr;
		exp_wr = cart ? ~prev_wr : prev_wr;  // Only cartridge writes toggle
		addr = a;
		data = d;
		wr = 1'b1;
		@(negedge clk_sys);
		wr = 1'b0;
		expect_eq("rom_wr", 128'(rom_wr), 128'(exp_wr));
		high = 0;
		while (cart && ioctl_wait && high < 20) begin
			high++;
			@(negedge clk_sys);
		end
		if (cart) begin
			checks++;
			assert (!ioctl_wait) else begin
				$display("ioctl_wait never fell after the write at 0x%0h", a);
				errors++;
			end
			expect_eq("ioctl_wait cycles", 128'(high), 128'(last_delay + 1));
		end
	endtask

	task automatic begin_download(input loader_pkg::index_t idx);
		index = idx;
		download = 1'b1;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic end_download();
		download = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	// ROM model acknowledging each toggle after 1 to 8 cycles
	always @(negedge clk_sys) begin
		if (RESET) begin
			rom_ack <= 1'b0;
			ack_cnt = 0;
		end else if (rom_ack != rom_wr) begin
			if (ack_cnt == 0) begin
				ack_rnd = lcg_next(ack_rnd);
				last_delay = (ack_rnd >> 16) % 8 + 1;
				ack_cnt = last_delay;
			end else begin
				ack_cnt = ack_cnt - 1;
				if (ack_cnt == 0)
					rom_ack <= rom_wr;
			end
		end
	end

	// Pulse counter and code compare
	always @(negedge clk_sys) begin
		if (code_reset)
			reset_pulses++;
		if (code_valid) begin
			valid_pulses++;
			expect_eq("code", 128'(code), 128'(exp_code));
		end
	end

	initial begin
		repeat (BUDGET) @(posedge clk_sys);
		$display("Run stopped by the watchdog after %0d cycles", BUDGET);
		$display("SOME TESTS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	initial begin
		int           mark;
		int           valid_before;
		int           reset_before;
		logic [79:0]  words;
		logic [127:0] cheat_ws;
		RESET = 1'b1;
		download = 1'b0;
		index = '0;
		wr = 1'b0;
		addr = '0;
		data = '0;
		cfg = '{auto_en: 1'b1, use_header: 1'b1, prio: loader_pkg::US_EU_JP};
		repeat (16) @(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);

		mark = errors;
		expect_eq("ioctl_wait", 128'(ioctl_wait), 128'(0));
		expect_eq("rom_wr", 128'(rom_wr), 128'(0));
		expect_eq("region_set", 128'(region_set), 128'(0));
		expect_eq("code_valid", 128'(code_valid), 128'(0));
		expect_eq("code_reset", 128'(code_reset), 128'(0));
		expect_eq("quirks", 128'(quirks), 128'(0));
		expect_eq("gun_cfg", 128'(gun_cfg), 128'(title_db_pkg::GUN_DEFAULT));
		test_done(1, "reset values", mark);

		mark = errors;
		begin_download(8'h00);
		for (int i = 0; i < CART_WORDS; i++)
			write_word(loader_pkg::addr_t'(2 * i), rand_word(), 1'b1);
		end_download();
		expect_eq("rom_sz", 128'(rom_sz), 128'(2 * (CART_WORDS - 1)));
		test_done(2, "cartridge write handshake", mark);

		mark = errors;
		for (int p = 0; p < 4; p++) begin
			for (int h = 0; h < 8; h++) begin
				cfg = '{auto_en: 1'b1, use_header: 1'b1, prio: prios[p]};
				begin_download(8'h00);
				write_word(loader_pkg::HDR_REGION0, hdr_w0[h], 1'b1);
				write_word(loader_pkg::HDR_REGION1, hdr_w1[h], 1'b1);
				write_word(loader_pkg::HDR_DONE, rand_word(), 1'b1);
				@(negedge clk_sys);
				expect_eq("region_set", 128'(region_set), 128'(1));
				expect_eq("region_req", 128'(region_req),
					128'(pick_region(header_flags(hdr_w0[h], hdr_w1[h]), prios[p])));
				end_download();
				expect_eq("region_set", 128'(region_set), 128'(0));
			end
		end
		test_done(3, "header region priority", mark);

		mark = errors;
		for (int n = 0; n < 5; n++) begin
			cfg = '{auto_en: (n < 4), use_header: 1'b0, prio: loader_pkg::US_EU_JP};
			begin_download(n < 4 ? idx_list[n] : 8'h40);  // Last pass has auto region off
			write_word(loader_pkg::HDR_DONE, rand_word(), 1'b1);
			@(negedge clk_sys);
			expect_eq("region_set", 128'(region_set), 128'(n < 4 && idx_list[n % 4] != 0));
			if (n < 4)
				expect_eq("region_req", 128'(region_req), 128'(idx_list[n][7:6]));
			end_download();
		end
		test_done(4, "index region and auto off", mark);

		mark = errors;
		for (int t = 0; t < 13; t++) begin
			words = {10{8'h20}};
			for (int i = 0; i < 8; i++)
				words[8*(i+1) +: 8] = ids[t][8*(7-i) +: 8];  // Char i at byte 0x183+i
			begin_download(8'h00);
			expect_eq("quirks", 128'(quirks), 128'(0));
			for (int k = 0; k < 5; k++)
				write_word(loader_pkg::ID_FIRST + loader_pkg::addr_t'(2 * k),
					words[16*k +: 16], 1'b1);
			write_word(loader_pkg::ID_DECIDE, rand_word(), 1'b1);
			@(negedge clk_sys);
			expect_eq("quirks", 128'(quirks), 128'(quirks_for_title(ids[t])));
			expect_eq("gun_cfg", 128'(gun_cfg), 128'(gun_for_title(ids[t])));
			end_download();
		end
		test_done(5, "title database", mark);

		mark = errors;
		for (int k = 0; k < 8; k++)
			cheat_ws[16*k +: 16] = rand_word();
		exp_code = assemble_cheat(cheat_ws);
		valid_before = valid_pulses;
		reset_before = reset_pulses;
		begin_download(8'hFF);
		for (int k = 0; k < 8; k++)
			write_word(loader_pkg::addr_t'(2 * k), cheat_ws[16*k +: 16], 1'b0);
		@(negedge clk_sys);
		end_download();
		expect_eq("code_valid pulses", 128'(valid_pulses - valid_before), 128'(1));
		expect_eq("code_reset pulses", 128'(reset_pulses - reset_before), 128'(1));
		expect_eq("code", 128'(code), 128'(exp_code));
		test_done(6, "cheat code assembly", mark);

		$display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: build.f
loader_pkg.sv
title_db_pkg.sv
load_ctrl.sv
hdr_region.sv
title_quirks.sv
region_select.sv
cart_loader_top.sv
tb_clock.sv
cart_loader_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the loader testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module cart_loader_tb -o cart_loader_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/cart_loader_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
	exit 0
fi
exit 1
